// File: src/motor_pkg.sv
package motor_pkg;

  // Command opcodes in the top byte of a header word
  localparam logic [7:0] op_nop    = 8'h00;
  localparam logic [7:0] op_move   = 8'h01;
  localparam logic [7:0] op_enable = 8'h0a;
  localparam logic [7:0] op_status = 8'hd0;

  typedef struct packed {
    logic [7:0]  opcode;
    logic [38:0] reserved;
    logic        dir;
    logic [15:0] half_period;  // Clocks per step level
  } cmd_header_t;

  typedef struct packed {
    logic [31:0] reserved;
    logic [31:0] step_count;
  } move_payload_t;

  // Same 64 bits, read by decoder state
  typedef union packed {
    cmd_header_t   header;
    move_payload_t payload;
  } cmd_word_u;

  typedef struct packed {
    logic      valid;  // One cycle pulse
    cmd_word_u word;
  } spi_word_t;

  typedef struct packed {
    logic        start;  // One cycle pulse
    logic        dir;
    logic [15:0] half_period;
    logic [31:0] step_count;
  } move_cmd_t;

  typedef struct packed {
    logic               cmd_error;  // Sticky until reset
    logic               enabled;
    logic               busy;
    logic [28:0]        reserved;
    logic signed [31:0] enc_count;
  } status_t;

endpackage

// File: src/spi_word_rx.sv
`timescale 1ns/1ps
module spi_word_rx #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                 CLK,
  input  logic                 resetn,
  input  logic                 sck,
  input  logic                 cs_n,
  input  logic                 copi,
  output logic                 cipo,
  output motor_pkg::spi_word_t rx,
  input  motor_pkg::status_t   reply,
  input  logic                 reply_load
);

  localparam int LAST = SYNC_STAGES - 1;

  logic [SYNC_STAGES-1:0] sck_sync;
  logic [SYNC_STAGES-1:0] cs_sync;
  logic [SYNC_STAGES-1:0] copi_sync;
  logic                   sck_d;
  logic                   selected;
  logic                   sck_rise;
  logic                   sck_fall;
  logic [2:0]             bit_cnt;
  logic [2:0]             byte_cnt;
  logic [6:0]             byte_sr;
  logic [7:0]             byte_next;
  logic [63:0]            word_q;
  logic                   valid_q;
  logic [63:0]            tx_q;
  logic                   cipo_q;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_sync  <= '0;
      cs_sync   <= '1;  // Deselected
      copi_sync <= '0;
      sck_d     <= 1'b0;
    end else begin
      sck_sync  <= {sck_sync[SYNC_STAGES-2:0], sck};
      cs_sync   <= {cs_sync[SYNC_STAGES-2:0], cs_n};
      copi_sync <= {copi_sync[SYNC_STAGES-2:0], copi};
      sck_d     <= sck_sync[LAST];
    end
  end

  assign selected  = !cs_sync[LAST];
  assign sck_rise  = selected && sck_sync[LAST] && !sck_d;
  assign sck_fall  = selected && !sck_sync[LAST] && sck_d;
  assign byte_next = {byte_sr, copi_sync[LAST]};  // MSB first

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_cnt  <= '0;
      byte_cnt <= '0;
      valid_q  <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (!selected) begin
        bit_cnt  <= '0;
        byte_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) begin
          byte_cnt <= byte_cnt + 3'd1;
          valid_q  <= (byte_cnt == 3'd7);  // Last byte of word
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (sck_rise) begin
      byte_sr <= byte_next[6:0];
      if (bit_cnt == 3'd7)
        word_q[byte_cnt*8 +: 8] <= byte_next;  // Low byte first
    end
  end

  assign rx = {valid_q, word_q};

  // Reply goes out during the word after the status command
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      tx_q   <= '0;
      cipo_q <= 1'b0;
    end else if (reply_load) begin
      tx_q   <= reply;
      cipo_q <= reply[7];  // First bit before any clock
    end else begin
      if (sck_rise && bit_cnt == 3'd7 && byte_cnt == 3'd7)
        tx_q <= '0;  // Reply spent
      if (sck_fall)
        cipo_q <= tx_q[{byte_cnt, ~bit_cnt}];
    end
  end

  assign cipo = cipo_q;

  rx_valid_single: assert property (@(posedge CLK) disable iff (!resetn)
    rx.valid |=> !rx.valid);

endmodule

// File: src/command_decoder.sv
`timescale 1ns/1ps
module command_decoder (
  input  logic                 CLK,
  input  logic                 resetn,
  input  motor_pkg::spi_word_t rx,
  input  logic                 busy,
  input  logic signed [31:0]   enc_count,
  output motor_pkg::move_cmd_t move,
  output logic                 enable,
  output motor_pkg::status_t   reply,
  output logic                 reply_load
);

  motor_pkg::cmd_header_t   hdr;
  motor_pkg::move_payload_t pay;
  logic                     expect_payload;  // Second word of a move
  logic                     move_ok;
  logic                     cmd_error;
  logic                     start_q;
  logic                     dir_q;
  logic [15:0]              half_q;
  logic [31:0]              count_q;

  assign hdr = rx.word.header;
  assign pay = rx.word.payload;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      expect_payload <= 1'b0;
      move_ok        <= 1'b0;
      cmd_error      <= 1'b0;
      enable         <= 1'b0;
      start_q        <= 1'b0;
      reply_load     <= 1'b0;
    end else begin
      start_q    <= 1'b0;
      reply_load <= 1'b0;
      if (rx.valid) begin
        if (expect_payload) begin
          expect_payload <= 1'b0;
          start_q        <= move_ok;
        end else begin
          case (hdr.opcode)
            motor_pkg::op_nop: ;  // Filler
            motor_pkg::op_enable: enable <= rx.word[0];
            motor_pkg::op_move: begin
              expect_payload <= 1'b1;  // Payload follows even if rejected
              move_ok        <= enable && !busy;
              if (!enable || busy)
                cmd_error <= 1'b1;
            end
            motor_pkg::op_status: reply_load <= 1'b1;
            default: cmd_error <= 1'b1;  // Unknown opcode
          endcase
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (rx.valid) begin
      if (expect_payload) begin
        count_q <= pay.step_count;
      end else if (hdr.opcode == motor_pkg::op_move) begin
        dir_q  <= hdr.dir;
        half_q <= hdr.half_period;
      end else if (hdr.opcode == motor_pkg::op_status) begin
        reply.cmd_error <= cmd_error;  // Snapshot at status word
        reply.enabled   <= enable;
        reply.busy      <= busy;
        reply.reserved  <= '0;
        reply.enc_count <= enc_count;
      end
    end
  end

  assign move = {start_q, dir_q, half_q, count_q};

  start_not_busy: assert property (@(posedge CLK) disable iff (!resetn)
    move.start |-> !busy);

endmodule

// File: src/step_generator.sv
`timescale 1ns/1ps
module step_generator (
  input  logic                 CLK,
  input  logic                 resetn,
  input  motor_pkg::move_cmd_t move,
  output logic                 step,
  output logic                 dir,
  output logic                 busy
);

  logic [15:0] half_eff;
  logic [15:0] half_q;
  logic [15:0] timer;
  logic [31:0] remain;  // Steps left, current one included

  assign half_eff = (move.half_period == 16'd0) ? 16'd1 : move.half_period;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      step <= 1'b0;
      dir  <= 1'b0;
      busy <= 1'b0;
    end else if (!busy) begin
      if (move.start && move.step_count != 32'd0) begin
        step <= 1'b1;
        dir  <= move.dir;
        busy <= 1'b1;
      end
    end else if (timer == 16'd0) begin
      if (step)
        step <= 1'b0;
      else if (remain == 32'd1)
        busy <= 1'b0;  // End of last low phase
      else
        step <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (!busy) begin
      if (move.start) begin
        half_q <= half_eff;
        timer  <= half_eff - 16'd1;
        remain <= move.step_count;
      end
    end else if (timer == 16'd0) begin
      timer <= half_q - 16'd1;
      if (!step)
        remain <= remain - 32'd1;
    end else begin
      timer <= timer - 16'd1;
    end
  end

  step_in_busy: assert property (@(posedge CLK) disable iff (!resetn)
    step |-> busy);

endmodule

// File: src/quad_decoder.sv
`timescale 1ns/1ps
module quad_decoder #(
  parameter int SYNC_STAGES = 2
) (
  input  logic               CLK,
  input  logic               resetn,
  input  logic               enc_a,
  input  logic               enc_b,
  output logic signed [31:0] enc_count
);

  logic [SYNC_STAGES-1:0] a_sync;
  logic [SYNC_STAGES-1:0] b_sync;
  logic [1:0]             ab_cur;
  logic [1:0]             ab_prev;

  assign ab_cur = {a_sync[SYNC_STAGES-1], b_sync[SYNC_STAGES-1]};

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      a_sync  <= '0;
      b_sync  <= '0;
      ab_prev <= 2'b00;
    end else begin
      a_sync  <= {a_sync[SYNC_STAGES-2:0], enc_a};
      b_sync  <= {b_sync[SYNC_STAGES-2:0], enc_b};
      ab_prev <= ab_cur;
    end
  end

  // A leading B walks 00 -> 10 -> 11 -> 01
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      enc_count <= '0;
    end else begin
      case ({ab_prev, ab_cur})
        4'b0010, 4'b1011, 4'b1101, 4'b0100: enc_count <= enc_count + 32'sd1;
        4'b0001, 4'b0111, 4'b1110, 4'b1000: enc_count <= enc_count - 32'sd1;
        default: enc_count <= enc_count;  // No change or double jump
      endcase
    end
  end

endmodule

// File: src/motor_front_top.sv
`timescale 1ns/1ps
module motor_front_top #(
  parameter int SYNC_STAGES = 2
) (
  input  logic CLK,
  input  logic resetn,
  input  logic sck,
  input  logic cs_n,
  input  logic copi,
  input  logic enc_a,
  input  logic enc_b,
  output logic cipo,
  output logic step,
  output logic dir,
  output logic enable,
  output logic busy
);

  motor_pkg::spi_word_t rx;
  motor_pkg::status_t   reply;
  logic                 reply_load;
  motor_pkg::move_cmd_t move;
  logic signed [31:0]   enc_count;

  spi_word_rx #(
    .SYNC_STAGES(SYNC_STAGES)
  ) u_spi (
    .CLK        (CLK),
    .resetn     (resetn),
    .sck        (sck),
    .cs_n       (cs_n),
    .copi       (copi),
    .cipo       (cipo),
    .rx         (rx),
    .reply      (reply),
    .reply_load (reply_load)
  );

  command_decoder u_decoder (
    .CLK        (CLK),
    .resetn     (resetn),
    .rx         (rx),
    .busy       (busy),
    .enc_count  (enc_count),
    .move       (move),
    .enable     (enable),
    .reply      (reply),
    .reply_load (reply_load)
  );

  step_generator u_step (
    .CLK    (CLK),
    .resetn (resetn),
    .move   (move),
    .step   (step),
    .dir    (dir),
    .busy   (busy)
  );

  quad_decoder #(
    .SYNC_STAGES(SYNC_STAGES)
  ) u_quad (
    .CLK       (CLK),
    .resetn    (resetn),
    .enc_a     (enc_a),
    .enc_b     (enc_b),
    .enc_count (enc_count)
  );

endmodule

// File: tests/motor_front_tb.sv
`timescale 1ns/1ps
module motor_front_tb;

  localparam int SYNC_STAGES  = 2;
  localparam int SPI_HOLD     = 4;  // CLK cycles per sck level
  localparam int RESET_CYCLES = 4;
  localparam int WAIT_LIMIT   = 5000;

  logic CLK = 1'b0;
  logic resetn;
  logic sck;
  logic cs_n;
  logic copi;
  logic enc_a;
  logic enc_b;
  logic cipo;
  logic step;
  logic dir;
  logic enable;
  logic busy;

  logic [15:0] lfsr;
  int          enc_phase;        // Gray state index, 0 is A=0 B=0
  logic        last_was_status;
  logic        payload_next;     // Next word is a move payload
  int          widths[$];        // High time of every step pulse
  int          widths_seen;
  int          high_len = 0;
  logic        step_prev = 1'b0;

  motor_front_top #(
    .SYNC_STAGES(SYNC_STAGES)
  ) DUT (
    .CLK    (CLK),
    .resetn (resetn),
    .sck    (sck),
    .cs_n   (cs_n),
    .copi   (copi),
    .enc_a  (enc_a),
    .enc_b  (enc_b),
    .cipo   (cipo),
    .step   (step),
    .dir    (dir),
    .enable (enable),
    .busy   (busy)
  );

  always #10 CLK = ~CLK;

  always @(negedge CLK) begin
    if (step)
      high_len = step_prev ? high_len + 1 : 1;
    else if (step_prev)
      widths.push_back(high_len);  // Pulse just ended
    step_prev = step;
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1, "testbench stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
      fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_word(input string name, input motor_pkg::cmd_word_u got,
                            input motor_pkg::cmd_word_u exp);
    if (got !== exp)
      fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_status(input string name, input motor_pkg::status_t got,
                              input motor_pkg::status_t exp);
    if (got !== exp)
      fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
  endtask

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic random_bits(input int n, output int value);
    int i;
    value = 0;
    for (i = 0; i < n; i++) begin
      lfsr  = lfsr_next(lfsr);
      value = value * 2 + int'(lfsr[0]);
    end
  endtask

  task automatic apply_reset();
    resetn          = 1'b0;
    cs_n            = 1'b1;
    sck             = 1'b0;
    copi            = 1'b0;
    enc_a           = 1'b0;
    enc_b           = 1'b0;
    enc_phase       = 0;
    last_was_status = 1'b0;
    payload_next    = 1'b0;
    repeat (RESET_CYCLES) @(negedge CLK);
    resetn = 1'b1;
    @(negedge CLK);
    cs_n = 1'b0;  // One frame for the whole sequence
  endtask

  // Low byte first, MSB first inside each byte
  task automatic send_word(input motor_pkg::cmd_word_u word, output logic [63:0] back);
    logic [63:0] bits;
    int          i;
    int          idx;
    bits = word;
    back = '0;
    for (i = 0; i < 64; i++) begin
      idx  = (i / 8) * 8 + 7 - (i % 8);
      copi = bits[idx];
      repeat (SPI_HOLD) @(negedge CLK);
      back[idx] = cipo;  // Sampled as sck rises
      sck       = 1'b1;
      repeat (SPI_HOLD) @(negedge CLK);
      sck = 1'b0;
    end
  endtask

  task automatic move_encoder(input logic signed [31:0] quarters);
    int n;
    int k;
    int hold;
    n = (quarters < 0) ? -quarters : quarters;
    for (k = 0; k < n; k++) begin
      enc_phase = (quarters < 0) ? (enc_phase + 3) % 4 : (enc_phase + 1) % 4;
      enc_a     = (enc_phase == 1) || (enc_phase == 2);
      enc_b     = (enc_phase == 2) || (enc_phase == 3);
      random_bits(3, hold);
      repeat (hold + 1) @(negedge CLK);
    end
  endtask

  task automatic wait_busy(input logic level, input string what);
    int t;
    t = 0;
    while (busy !== level) begin
      @(negedge CLK);
      t++;
      if (t > WAIT_LIMIT)
        fail_run($sformatf("timeout while waiting for %s", what));
    end
  endtask

  task automatic check_enable_busy(input logic exp_enable, input logic exp_busy);
    repeat (SYNC_STAGES + 2) @(negedge CLK);  // Decode and start latency
    check_bit("enable", enable, exp_enable);
    check_bit("busy", busy, exp_busy);
  endtask

  task automatic check_move(input int pulses, input logic exp_dir, input int half);
    int k;
    wait_busy(1'b1, "busy to rise at the start of a move");
    wait_busy(1'b0, "busy to fall at the end of a move");
    check_bit("step", step, 1'b0);
    check_count("step pulses", widths.size() - widths_seen, pulses);
    for (k = widths_seen; k < widths.size(); k++)
      check_count("step high cycles", widths[k], half);
    check_bit("dir", dir, exp_dir);
    widths_seen = widths.size();
  endtask

  task automatic run_line(input int fd, input byte kind);
    logic [63:0]          f1;
    logic [63:0]          f2;
    logic [63:0]          f3;
    logic [63:0]          back;
    int                   n;
    motor_pkg::cmd_word_u sent;
    f1 = '0;
    f2 = '0;
    f3 = '0;
    case (kind)
      "S": begin
        n = $fscanf(fd, "%h %h", f1, f2);
        if (n != 2)
          fail_run("an S line in the test file lacks its two fields");
        sent = f1;
        send_word(sent, back);
        if (last_was_status)
          check_status("reply", back, f2);
        else
          check_word("cipo", back, f2);  // Idle words return zeros
        last_was_status = !payload_next && (sent.header.opcode == motor_pkg::op_status);
        payload_next    = !payload_next && (sent.header.opcode == motor_pkg::op_move);
      end
      "E": begin
        n = $fscanf(fd, "%h", f1);
        if (n != 1)
          fail_run("an E line in the test file lacks its step field");
        move_encoder(f1[31:0]);
      end
      "M": begin
        n = $fscanf(fd, "%h %h %h", f1, f2, f3);
        if (n != 3)
          fail_run("an M line in the test file lacks one of its three fields");
        check_move(int'(f1[31:0]), f2[0], int'(f3[15:0]));
      end
      "C": begin
        n = $fscanf(fd, "%h %h", f1, f2);
        if (n != 2)
          fail_run("a C line in the test file lacks its two fields");
        check_enable_busy(f1[0], f2[0]);
      end
      "R": apply_reset();
      default: fail_run($sformatf("the test file holds an unknown line kind %c", kind));
    endcase
  endtask

  initial begin
    int  fd;
    int  c;
    byte kind;
    lfsr        = 16'd28305;
    widths_seen = 0;
    apply_reset();
    check_bit("step", step, 1'b0);
    check_bit("busy", busy, 1'b0);
    check_bit("enable", enable, 1'b0);
    check_bit("cipo", cipo, 1'b0);
    fd = $fopen("tests/motor_front_tests.txt", "r");
    if (fd == 0)
      fail_run("could not open tests/motor_front_tests.txt");
    while ($fscanf(fd, " %c", kind) == 1) begin
      if (kind == "#") begin
        c = 0;
        while (c != 10 && c != -1)  // Skip to newline
          c = $fgetc(fd);
      end else begin
        run_line(fd, kind);
      end
    end
    $fclose(fd);
    if (widths.size() != widths_seen) begin
      fail_run("step pulses appeared outside a checked move");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

// File: tests/motor_front_tests.txt
# S word reply    E quarter_steps    M pulses dir half_period
# C enable busy   R reset            all fields hex, E in two's complement
S d000000000000000 0000000000000000
S 0000000000000000 0000000000000000
# Move while disabled
S 0100000000010002 0000000000000000
S 0100000000000004 0000000000000000
C 0 0
S d000000000000000 0000000000000000
S 0000000000000000 8000000000000000
R
S 0a00000000000001 0000000000000000
C 1 0
S 0100000000010003 0000000000000000
S 0000000000000005 0000000000000000
M 00000005 1 0003
E 0000000a
E fffffffd
E 00000002
S d000000000000000 0000000000000000
S 0000000000000000 4000000000000009
# Move while busy
S 0100000000000020 0000000000000000
S 0000000000000014 0000000000000000
S 0100000000010001 0000000000000000
S 0100000000000007 0000000000000000
M 00000014 0 0020
C 1 0
S d000000000000000 0000000000000000
S 0000000000000000 c000000000000009
S 0100000000010002 0000000000000000
S 0000000000000006 0000000000000000
M 00000006 1 0002
R
# Unknown opcode
S 0a00000000000001 0000000000000000
S 5500000000000000 0000000000000000
C 1 0
S d000000000000000 0000000000000000
S 0000000000000000 c000000000000000
S 0a00000000000000 0000000000000000
C 0 0
S d000000000000000 0000000000000000
S 0000000000000000 8000000000000000
S 0000000000000000 0000000000000000

// File: all.f
src/motor_pkg.sv
src/spi_word_rx.sv
src/command_decoder.sv
src/step_generator.sv
src/quad_decoder.sv
src/motor_front_top.sv
tests/motor_front_tb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f all.f --top-module motor_front_tb -o motor_front_sim \
  && ./obj_dir/motor_front_sim > sim.log 2>&1
grep -q "^=== PASS ===$" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
